// ==== all.f ====
+incdir+include
hdl/exec_pkg.sv
hdl/alu.sv
hdl/int_pipe.sv
hdl/mem_pipe.sv
hdl/mem_arbiter.sv
hdl/data_mem.sv
hdl/exec_cluster.sv
tb/tb_clock.sv
tb/exec_cluster_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the execution cluster testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f all.f --top-module exec_cluster_tb -o exec_cluster_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/exec_cluster_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// ==== tb/exec_cluster_tb.sv ====
/*
 * Execution cluster testbench: random integer and memory stimulus,
 * reference model with shadow memory, result checker and run timeout
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_cluster_tb import exec_pkg::*; ();

  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    int               due;
    tag_t             tag;
    logic [`XLEN-1:0] data;
  } int_exp_t;

  logic        clock;
  logic        reset;
  exec_req_t   int_issue;
  exec_req_t   mem0_issue;
  exec_req_t   mem1_issue;
  result_t     int_result;
  result_t     mem0_result;
  result_t     mem1_result;
  logic        mem0_busy;
  logic        mem1_busy;

  int          cycle = 0;
  logic [31:0] rng_state;
  tag_t        int_tag;
  tag_t        mem_tag;
  int_exp_t    int_exp [$];
  int_exp_t    int_head;
  logic [7:0]  shadow [1024];
  int          mem_issued [2];
  int          mem_done [2];
  tag_t        mem_exp_tag [2];
  logic [31:0] mem_exp_data [2];
  bit          mem_phase_done;

  tb_clock tb_clock_inst (.clock(clock));

  exec_cluster exec_cluster_inst (
    .clock       (clock),
    .reset       (reset),
    .int_issue   (int_issue),
    .mem0_issue  (mem0_issue),
    .mem1_issue  (mem1_issue),
    .int_result  (int_result),
    .mem0_result (mem0_result),
    .mem1_result (mem1_result),
    .mem0_busy   (mem0_busy),
    .mem1_busy   (mem1_busy)
  );

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Expected integer pipe result from the ISA rules
  function automatic logic [31:0] exec_ref(fu_code_t fu, alu_op_t op,
                                           logic [31:0] a, logic [31:0] b);
    logic [63:0] prod;
    logic [63:0] ext;
    logic [4:0]  sh;
    prod = {32'b0, a} * {32'b0, b};
    ext  = {{32{a[31]}}, a};
    sh   = b[4:0];
    if (fu == FU_IMUL) return prod[31:0];
    case (op)
      ADD:  return a + b;
      SUB:  return a + ~b + 32'd1;
      AND:  return a & b;
      OR:   return a | b;
      XOR:  return a ^ b;
      SLL:  return a << sh;
      SRL:  return a >> sh;
      SRA: begin
        ext = ext >> sh;
        return ext[31:0];
      end
      SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      SLTU: return {31'b0, a < b};
      default: return 32'b0;
    endcase
  endfunction

  function automatic int size_bytes(mem_size_t sz);
    case (sz)
      MEM_BYTE: return 1;
      MEM_HALF: return 2;
      default:  return 4;
    endcase
  endfunction

  // Naturally aligned offset inside a word
  function automatic logic [31:0] lane_offset(mem_size_t sz, logic [31:0] r);
    case (sz)
      MEM_BYTE: return {30'b0, r[1:0]};
      MEM_HALF: return {30'b0, r[0], 1'b0};
      default:  return 32'b0;
    endcase
  endfunction

  function automatic void shadow_write(logic [31:0] addr, mem_size_t sz, logic [31:0] data);
    for (int i = 0; i < size_bytes(sz); i++) begin
      shadow[int'(addr[9:0]) + i] = data[8*i +: 8];
    end
  endfunction

  function automatic logic [31:0] load_ref(logic [31:0] addr, mem_size_t sz, mem_type_t mt);
    logic [31:0] v;
    int          n;
    n = size_bytes(sz);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = shadow[int'(addr[9:0]) + i];
    end
    if (mt == MEM_LD && n < 4 && v[8*n-1]) v = v | (32'hffff_ffff << (8*n));
    return v;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    $display("RESULT: FAIL");
  endtask

  task automatic report_error(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("RESULT: FAIL");
  endtask

  task automatic tick();
    @(posedge clock);
    #2;
  endtask

  task automatic issue_int(fu_code_t fu, alu_op_t op, logic [31:0] a, logic [31:0] b);
    exec_req_t r;
    int_exp_t  e;
    r             = '0;
    r.uop.valid   = 1'b1;
    r.uop.tag     = int_tag;
    r.uop.fu_code = fu;
    r.uop.alu_op  = op;
    r.in1         = a;
    r.in2         = b;
    int_issue     = r;
    if (fu == FU_ALU || fu == FU_IMUL) begin
      e.due  = cycle + `IMUL_LATENCY;
      e.tag  = int_tag;
      e.data = exec_ref(fu, op, a, b);
      int_exp.push_back(e);
    end
    int_tag++;
    tick();
  endtask

  // Mixed mode adds multiplies and ops the integer pipe must drop
  task automatic random_int_op(bit mixed);
    logic [31:0] r;
    logic [3:0]  opn;
    fu_code_t    fu;
    r   = rand32();
    opn = 4'((r >> 8) % 10);
    fu  = FU_ALU;
    if (mixed && r[2:0] == 3'd0) fu = FU_NONE;
    else if (mixed && r[2:0] < 3'd4) fu = FU_IMUL;
    issue_int(fu, alu_op_t'(opn), rand32(), rand32());
  endtask

  task automatic issue_mem(int pipe, mem_type_t mt, mem_size_t sz,
                           logic [31:0] addr, logic [31:0] data);
    exec_req_t   r;
    logic [31:0] base;
    base           = rand32();
    r              = '0;
    r.uop.valid    = 1'b1;
    r.uop.tag      = mem_tag;
    r.uop.fu_code  = FU_MEM;
    r.uop.mem_type = mt;
    r.uop.mem_size = sz;
    r.uop.imm      = addr - base;
    r.in1          = base;
    r.in2          = data;
    mem_exp_tag[pipe] = mem_tag;
    if (mt == MEM_ST) begin
      shadow_write(addr, sz, data);
      mem_exp_data[pipe] = '0;
    end else begin
      mem_exp_data[pipe] = load_ref(addr, sz, mt);
    end
    mem_issued[pipe]++;
    if (pipe == 0) mem0_issue = r;
    else mem1_issue = r;
    mem_tag++;
  endtask

  // A pipe that took an op is busy from the following cycle
  task automatic expect_busy(int pipe, logic busy_now);
    assert (busy_now) else begin
      report_mismatch($sformatf("mem%0d_busy", pipe), 32'(busy_now), 32'd1);
      $fatal(1);
    end
  endtask

  task automatic wait_mem_done();
    while (mem_issued[0] != mem_done[0] || mem_issued[1] != mem_done[1]) begin
      tick();
    end
  endtask

  task automatic run_single(mem_type_t mt, mem_size_t sz, logic [31:0] addr,
                            logic [31:0] data);
    issue_mem(0, mt, sz, addr, data);
    tick();
    mem0_issue = '0;
    expect_busy(0, mem0_busy);
    wait_mem_done();
  endtask

  task automatic run_pair(mem_type_t mt0, mem_size_t sz0, logic [31:0] a0, logic [31:0] d0,
                          mem_type_t mt1, mem_size_t sz1, logic [31:0] a1, logic [31:0] d1);
    issue_mem(0, mt0, sz0, a0, d0);
    issue_mem(1, mt1, sz1, a1, d1);
    tick();
    mem0_issue = '0;
    mem1_issue = '0;
    expect_busy(0, mem0_busy);
    expect_busy(1, mem1_busy);
    wait_mem_done();
  endtask

  task automatic check_int();
    if (int_result.valid) begin
      assert (int_exp.size() > 0) else begin
        report_error("int_result valid with no integer op in flight");
        $fatal(1);
      end
      int_head = int_exp.pop_front();
      assert (int_head.due == cycle) else begin
        report_mismatch("int_result cycle", cycle, int_head.due);
        $fatal(1);
      end
      assert (int_result.tag == int_head.tag) else begin
        report_mismatch("int_result.tag", 32'(int_result.tag), 32'(int_head.tag));
        $fatal(1);
      end
      assert (int_result.data == int_head.data) else begin
        report_mismatch("int_result.data", int_result.data, int_head.data);
        $fatal(1);
      end
    end else if (int_exp.size() > 0) begin
      assert (int_exp[0].due > cycle) else begin
        report_error("integer result missing at its due cycle");
        $fatal(1);
      end
    end
  endtask

  task automatic check_mem(int pipe, result_t res, logic busy_now);
    if (res.valid) begin
      assert (mem_issued[pipe] != mem_done[pipe]) else begin
        report_error($sformatf("result pulse on memory pipe %0d with no op outstanding", pipe));
        $fatal(1);
      end
      assert (res.tag == mem_exp_tag[pipe]) else begin
        report_mismatch($sformatf("mem%0d_result.tag", pipe), 32'(res.tag),
                        32'(mem_exp_tag[pipe]));
        $fatal(1);
      end
      assert (res.data == mem_exp_data[pipe]) else begin
        report_mismatch($sformatf("mem%0d_result.data", pipe), res.data, mem_exp_data[pipe]);
        $fatal(1);
      end
      assert (!busy_now) else begin
        report_mismatch($sformatf("mem%0d_busy", pipe), 32'(busy_now), 32'd0);
        $fatal(1);
      end
      mem_done[pipe]++;
    end
  endtask

  task automatic check_idle();
    assert (!mem0_busy && !mem1_busy) else begin
      report_mismatch("mem0_busy/mem1_busy", {30'b0, mem1_busy, mem0_busy}, 32'd0);
      $fatal(1);
    end
  endtask

  // Outputs are compared half a cycle after the edge that updates them
  initial begin
    forever begin
      @(negedge clock);
      if (!reset) begin
        check_int();
        check_mem(0, mem0_result, mem0_busy);
        check_mem(1, mem1_result, mem1_busy);
      end
    end
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      report_error($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
      $fatal(1);
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] wa;
    mem_size_t   sz;
    mem_type_t   mt;
    reset          = 1'b1;
    int_issue      = '0;
    mem0_issue     = '0;
    mem1_issue     = '0;
    rng_state      = 32'hd5ae;
    int_tag        = '0;
    mem_tag        = '0;
    mem_phase_done = 1'b0;
    repeat (10) @(posedge clock);
    #2;
    reset = 1'b0;

    // Quiet after reset
    repeat (5) begin
      tick();
      check_idle();
    end

    for (int i = 0; i < 200; i++) begin
      random_int_op(1'b0);
    end
    for (int i = 0; i < 100; i++) begin
      random_int_op(1'b1);
    end
    int_issue = '0;

    // Stores then loads of every size on pipe 0
    for (int k = 0; k < 10; k++) begin
      r  = rand32();
      wa = {r[31:2], 2'b00};
      run_single(MEM_ST, MEM_WORD, wa, rand32());
      r = rand32();
      run_single(MEM_ST, MEM_HALF, wa + lane_offset(MEM_HALF, r), rand32());
      r = rand32();
      run_single(MEM_ST, MEM_BYTE, wa + lane_offset(MEM_BYTE, r), rand32());
      for (int s = 0; s < 3; s++) begin
        for (int t = 0; t < 2; t++) begin
          r  = rand32();
          sz = mem_size_t'(s[1:0]);
          mt = t[0] ? MEM_LDU : MEM_LD;
          run_single(mt, sz, wa + lane_offset(sz, r), 32'b0);
        end
      end
    end

    // Both memory pipes at once while the integer pipe streams
    fork
      begin
        for (int k = 0; k < 8; k++) begin
          r  = rand32();
          wa = {r[31:2], 2'b00};
          run_single(MEM_ST, MEM_WORD, wa, rand32());
          r = rand32();
          if (r[4]) begin
            run_pair(MEM_ST, MEM_BYTE, wa + {30'b0, r[1:0]}, rand32(),
                     MEM_ST, MEM_BYTE, wa + {30'b0, r[1:0] ^ {r[2], 1'b1}}, rand32());
          end else begin
            run_pair(MEM_ST, MEM_HALF, wa + {30'b0, r[1], 1'b0}, rand32(),
                     MEM_ST, MEM_BYTE, wa + {30'b0, ~r[1], r[0]}, rand32());
          end
          r  = rand32();
          sz = r[5] ? MEM_HALF : MEM_BYTE;
          run_pair(MEM_LDU, MEM_WORD, wa, 32'b0,
                   MEM_LD, sz, wa + lane_offset(sz, r), 32'b0);
        end
        mem_phase_done = 1'b1;
      end
      begin
        while (!mem_phase_done) begin
          random_int_op(1'b1);
        end
        int_issue = '0;
      end
    join

    repeat (`IMUL_LATENCY + 2) tick();
    if (int_exp.size() == 0 && mem_issued[0] == mem_done[0] &&
        mem_issued[1] == mem_done[1]) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      report_error("results still outstanding at the end of the run");
      $fatal(1);
    end
  end

endmodule

// ==== tb/tb_clock.sv ====
/*
 * Testbench clock source, 20 ns period
 */
`timescale 1ns/10ps

module tb_clock (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever begin
      #10 clock = ~clock;
    end
  end

endmodule

// ==== hdl/exec_cluster.sv ====
/*
 * Execution cluster top: integer pipe, two load/store pipes,
 * memory arbiter and data memory
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module exec_cluster import exec_pkg::*; (
  input             clock,
  input             reset,
  input  exec_req_t int_issue,
  input  exec_req_t mem0_issue,
  input  exec_req_t mem1_issue,
  output result_t   int_result,
  output result_t   mem0_result,
  output result_t   mem1_result,
  output logic      mem0_busy,
  output logic      mem1_busy
);

  mem_req_t         m0_req_pkt;
  mem_req_t         m1_req_pkt;
  mem_req_t         dm_req_pkt;
  logic             m0_req;
  logic             m0_ack;
  logic             m1_req;
  logic             m1_ack;
  logic             dm_req;
  logic             dm_ack;
  logic [`XLEN-1:0] m0_rdata;
  logic [`XLEN-1:0] m1_rdata;
  logic [`XLEN-1:0] dm_rdata;

  int_pipe int_pipe_inst (
    .clock  (clock),
    .reset  (reset),
    .issue  (int_issue),
    .result (int_result)
  );

  mem_pipe mem_pipe_0 (
    .clock   (clock),
    .reset   (reset),
    .issue   (mem0_issue),
    .result  (mem0_result),
    .busy    (mem0_busy),
    .mem_req (m0_req_pkt),
    .req     (m0_req),
    .ack     (m0_ack),
    .rdata   (m0_rdata)
  );

  mem_pipe mem_pipe_1 (
    .clock   (clock),
    .reset   (reset),
    .issue   (mem1_issue),
    .result  (mem1_result),
    .busy    (mem1_busy),
    .mem_req (m1_req_pkt),
    .req     (m1_req),
    .ack     (m1_ack),
    .rdata   (m1_rdata)
  );

  mem_arbiter mem_arbiter_inst (
    .clock    (clock),
    .reset    (reset),
    .req0     (m0_req),
    .mem_req0 (m0_req_pkt),
    .ack0     (m0_ack),
    .rdata0   (m0_rdata),
    .req1     (m1_req),
    .mem_req1 (m1_req_pkt),
    .ack1     (m1_ack),
    .rdata1   (m1_rdata),
    .mem_req  (dm_req_pkt),
    .req      (dm_req),
    .ack      (dm_ack),
    .rdata    (dm_rdata)
  );

  data_mem data_mem_inst (
    .clock   (clock),
    .reset   (reset),
    .mem_req (dm_req_pkt),
    .req     (dm_req),
    .ack     (dm_ack),
    .rdata   (dm_rdata)
  );

endmodule

// ==== hdl/data_mem.sv ====
/*
 * Word-organized data memory with byte-lane writes,
 * answering each request through a four-phase responder
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module data_mem import exec_pkg::*; (
  input                    clock,
  input                    reset,
  input  mem_req_t         mem_req,
  input                    req,
  output logic             ack,
  output logic [`XLEN-1:0] rdata
);

  localparam int IDX_W = $clog2(`MEM_WORDS);
  localparam int LANES = `XLEN / 8;

  logic [`XLEN-1:0] mem [`MEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [LANES-1:0] lane_en;
  logic             start;

  assign idx   = mem_req.addr[IDX_W+1:2];
  assign start = req && !ack;

  always_comb begin
    case (mem_req.size)
      MEM_BYTE: lane_en = {{(LANES-1){1'b0}}, 1'b1} << mem_req.addr[1:0];
      MEM_HALF: lane_en = {{(LANES-2){1'b0}}, 2'b11} << {mem_req.addr[1], 1'b0};
      default:  lane_en = '1;
    endcase
  end

  always_ff @(posedge clock) begin
    if (start) begin
      if (mem_req.we) begin
        for (int i = 0; i < LANES; i++) begin
          if (lane_en[i]) mem[idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
        end
      end else begin
        rdata <= mem[idx];
      end
    end
  end

  // Ack follows req by one cycle in both directions
  always_ff @(posedge clock) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (start) begin
      ack <= 1'b1;
    end else if (!req && ack) begin
      ack <= 1'b0;
    end
  end

endmodule

// ==== hdl/mem_arbiter.sv ====
/*
 * Round-robin arbiter joining two load/store pipes onto the
 * data memory over four-phase req/ack links
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module mem_arbiter import exec_pkg::*; (
  input                    clock,
  input                    reset,
  input                    req0,
  input  mem_req_t         mem_req0,
  output logic             ack0,
  output logic [`XLEN-1:0] rdata0,
  input                    req1,
  input  mem_req_t         mem_req1,
  output logic             ack1,
  output logic [`XLEN-1:0] rdata1,
  output mem_req_t         mem_req,
  output logic             req,
  input                    ack,
  input  [`XLEN-1:0]       rdata
);

  logic [1:0] grant;
  logic       last;
  logic       pick;

  // On a tie the pipe not granted last wins
  assign pick = (req0 && req1) ? ~last : req1;

  always_ff @(posedge clock) begin
    if (reset) begin
      grant <= 2'b00;
      last  <= 1'b0;
    end else if (grant == 2'b00) begin
      if (req0 || req1) begin
        grant <= pick ? 2'b10 : 2'b01;
        last  <= pick;
      end
    end else if (!req && !ack) begin
      // Transfer closed, both req and ack back low
      grant <= 2'b00;
    end
  end

  assign mem_req = grant[1] ? mem_req1 : mem_req0;
  assign req     = (grant[0] && req0) || (grant[1] && req1);

  assign ack0   = grant[0] && ack;
  assign ack1   = grant[1] && ack;
  assign rdata0 = grant[0] ? rdata : '0;
  assign rdata1 = grant[1] ? rdata : '0;

endmodule

// ==== hdl/mem_pipe.sv ====
/*
 * Load/store pipe: address generation, store lane placement,
 * four-phase request FSM and load extension
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module mem_pipe import exec_pkg::*; (
  input                    clock,
  input                    reset,
  input  exec_req_t        issue,
  output result_t          result,
  output logic             busy,
  output mem_req_t         mem_req,
  output logic             req,
  input                    ack,
  input  [`XLEN-1:0]       rdata
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_RELEASE} state_t;

  state_t           state;
  logic             accept;
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] lane_data;
  logic [`XLEN-1:0] shifted;
  logic [`XLEN-1:0] ld_data;
  mem_type_t        type_q;
  logic             res_valid;
  tag_t             res_tag;
  logic [`XLEN-1:0] res_data;

  assign accept = issue.uop.valid && issue.uop.fu_code == FU_MEM && state == S_IDLE;
  assign addr   = issue.in1 + issue.uop.imm;

  // Store data moved onto the lanes it is written to
  always_comb begin
    case (issue.uop.mem_size)
      MEM_BYTE: lane_data = {{(`XLEN-8){1'b0}}, issue.in2[7:0]} << {addr[1:0], 3'b000};
      MEM_HALF: lane_data = {{(`XLEN-16){1'b0}}, issue.in2[15:0]} << {addr[1], 4'b0000};
      default:  lane_data = issue.in2;
    endcase
  end

  // Pick the addressed part of the word and extend it
  always_comb begin
    shifted = rdata >> {mem_req.addr[1:0], 3'b000};
    case (mem_req.size)
      MEM_BYTE: ld_data = (type_q == MEM_LD) ? {{(`XLEN-8){shifted[7]}}, shifted[7:0]}
                                             : {{(`XLEN-8){1'b0}}, shifted[7:0]};
      MEM_HALF: ld_data = (type_q == MEM_LD) ? {{(`XLEN-16){shifted[15]}}, shifted[15:0]}
                                             : {{(`XLEN-16){1'b0}}, shifted[15:0]};
      default:  ld_data = rdata;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= S_IDLE;
      res_valid <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      case (state)
        S_IDLE:    if (accept) state <= S_REQ;
        S_REQ:     if (ack) state <= S_RELEASE;
        S_RELEASE: begin
          // Done once the responder has dropped ack
          if (!ack) begin
            state     <= S_IDLE;
            res_valid <= 1'b1;
          end
        end
        default:   state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      mem_req.we    <= issue.uop.mem_type == MEM_ST;
      mem_req.size  <= issue.uop.mem_size;
      mem_req.addr  <= addr;
      mem_req.wdata <= lane_data;
      type_q        <= issue.uop.mem_type;
      res_tag       <= issue.uop.tag;
    end
    if (state == S_REQ && ack) begin
      res_data <= mem_req.we ? '0 : ld_data;
    end
  end

  assign req    = state == S_REQ;
  assign busy   = state != S_IDLE;
  assign result = '{valid: res_valid, tag: res_tag, data: res_data};

endmodule

// ==== hdl/int_pipe.sv ====
/*
 * Integer pipe pairing the ALU with a multiplier; both results
 * travel through one shift line so every op has the same latency
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module int_pipe import exec_pkg::*; (
  input             clock,
  input             reset,
  input  exec_req_t issue,
  output result_t   result
);

  logic [`XLEN-1:0] alu_y;
  logic [`XLEN-1:0] product;
  logic             is_alu;
  logic             is_mul;
  result_t          entry;
  result_t          line [`IMUL_LATENCY];

  alu alu_inst (
    .op (issue.uop.alu_op),
    .a  (issue.in1),
    .b  (issue.in2),
    .y  (alu_y)
  );

  // Low half of the product, same bits for signed and unsigned
  assign product = issue.in1 * issue.in2;

  assign is_alu = issue.uop.fu_code == FU_ALU;
  assign is_mul = issue.uop.fu_code == FU_IMUL;

  always_comb begin
    entry.valid = issue.uop.valid && (is_alu || is_mul);
    entry.tag   = issue.uop.tag;
    entry.data  = is_mul ? product : alu_y;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `IMUL_LATENCY; i++) begin
        line[i] <= '0;
      end
    end else begin
      line[0] <= entry;
      for (int i = 1; i < `IMUL_LATENCY; i++) begin
        line[i] <= line[i-1];
      end
    end
  end

  assign result = line[`IMUL_LATENCY-1];

endmodule

// ==== hdl/alu.sv ====
/*
 * Combinational integer ALU: add, sub, logic ops, shifts
 * and signed/unsigned set-less-than
 */
`timescale 1ns/10ps
`include "exec_defines.svh"

module alu import exec_pkg::*; (
  input  alu_op_t           op,
  input  [`XLEN-1:0]        a,
  input  [`XLEN-1:0]        b,
  output logic [`XLEN-1:0]  y
);

  logic [4:0] shamt;

  // Only the low five bits of b count as shift amount
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ADD:  y = a + b;
      SUB:  y = a - b;
      AND:  y = a & b;
      OR:   y = a | b;
      XOR:  y = a ^ b;
      SLL:  y = a << shamt;
      SRL:  y = a >> shamt;
      SRA:  y = $signed(a) >>> shamt;
      SLT: begin
        y = '0;
        y[0] = $signed(a) < $signed(b);
      end
      SLTU: begin
        y = '0;
        y[0] = a < b;
      end
      default: y = '0;
    endcase
  end

endmodule

// ==== hdl/exec_pkg.sv ====
/*
 * Shared types of the execution cluster: unit and op encodings,
 * micro-op, issue slot, result and memory request structs
 */
`include "exec_defines.svh"

package exec_pkg;

  typedef logic [5:0] tag_t;

  typedef enum logic [1:0] {
    FU_NONE, FU_ALU, FU_IMUL, FU_MEM
  } fu_code_t;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
  } alu_op_t;

  // MEM_LD sign-extends, MEM_LDU zero-extends
  typedef enum logic [1:0] {
    MEM_LD, MEM_LDU, MEM_ST
  } mem_type_t;

  typedef enum logic [1:0] {
    MEM_BYTE, MEM_HALF, MEM_WORD
  } mem_size_t;

  typedef struct packed {
    logic              valid;
    tag_t              tag;
    fu_code_t          fu_code;
    alu_op_t           alu_op;
    mem_type_t         mem_type;
    mem_size_t         mem_size;
    logic [`XLEN-1:0]  imm;
  } micro_op_t;

  // One issue slot with its operand values
  typedef struct packed {
    micro_op_t         uop;
    logic [`XLEN-1:0]  in1;
    logic [`XLEN-1:0]  in2;
  } exec_req_t;

  typedef struct packed {
    logic              valid;
    tag_t              tag;
    logic [`XLEN-1:0]  data;
  } result_t;

  typedef struct packed {
    logic              we;
    mem_size_t         size;
    logic [`XLEN-1:0]  addr;
    logic [`XLEN-1:0]  wdata;
  } mem_req_t;

endpackage

// ==== include/exec_defines.svh ====
/*
 * Global sizing macros for the integer execution cluster:
 * data width, integer pipe latency and data memory depth
 */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Data and address width
`define XLEN 32

// Cycles from issue to result on the integer pipe
`define IMUL_LATENCY 3

// Data memory size in 32-bit words, indexed by address bits 9 to 2
`define MEM_WORDS 256

`endif
